// File: all.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/regfile.sv
logic/fetch_unit.sv
logic/insn_queue.sv
logic/exec_unit.sv
logic/rv_core_top.sv
dv/imem_model.sv
dv/rv_core_tb.sv

// File: Makefile
TOP := rv_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-f all.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb
  import rv_isa_pkg::*;
  import core_pkg::*;
();

  localparam int    clk_period   = 100;
  localparam int    rst_cycles   = 16;
  localparam int    drain_cycles = 16;
  localparam int    mem_words    = 512;
  localparam int    rand_seed    = 32'hde4ec4e9;
  localparam word_t start_pc     = 32'h0000_0100;
  localparam word_t ecall_word   = 32'h0000_0073;
  // LUI and ADDI for each of x1..x31
  localparam int    init_len     = 62;
  localparam int    len_imm      = 120;
  localparam int    len_reg      = 120;
  localparam int    len_x0       = 60;
  localparam int    len_stall    = 150;
  localparam int    len_halt     = 20;
  localparam int    watchdog_cycles =
      20 * (5 * (init_len + 1) + len_imm + len_reg + len_x0 + len_stall + len_halt) +
      5 * (rst_cycles + drain_cycles + 2);

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  int        stall_pct = 0;
  logic      imem_req_ready;
  logic      imem_req_valid;
  imem_req_t imem_req;
  logic      imem_rsp_valid;
  word_t     imem_rsp;
  logic      retire_valid;
  retire_t   retire;
  logic      halt;

  integer seed = rand_seed;
  string  test_name = "none";
  int     errors = 0;
  int     tests_failed = 0;
  int     prog_len = 0;
  int     retire_count;
  word_t  prog [mem_words];
  word_t  model_regs [32];
  word_t  exp_pc;
  word_t  exp_insn;
  logic   exp_we;
  word_t  exp_value;

  always #(clk_period / 2) clk = ~clk;

  rv_core_top #(
    .queue_depth (4),
    .reset_pc    (start_pc)
  ) rv_core_top_i (
    .clk              (clk),
    .rst              (rst),
    .imem_req_ready_i (imem_req_ready),
    .imem_req_valid_o (imem_req_valid),
    .imem_req_o       (imem_req),
    .imem_rsp_valid_i (imem_rsp_valid),
    .imem_rsp_i       (imem_rsp),
    .retire_valid_o   (retire_valid),
    .retire_o         (retire),
    .halt_o           (halt)
  );

  imem_model #(
    .mem_words (mem_words),
    .seed_init (rand_seed)
  ) imem_i (
    .clk         (clk),
    .rst         (rst),
    .stall_pct_i (stall_pct),
    .req_valid_i (imem_req_valid),
    .req_i       (imem_req),
    .req_ready_o (imem_req_ready),
    .rsp_valid_o (imem_rsp_valid),
    .rsp_o       (imem_rsp)
  );

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // kind 0 reg-imm, 1 reg-reg, 2 LUI and x0 traffic, 3 a mix of all
  function automatic word_t gen_op(input int kind);
    word_t       r;
    word_t       s;
    reg_idx_t    rd;
    logic [11:0] imm;
    logic [6:0]  f7;
    int          k;
    r = rand_word();
    s = rand_word();
    rd = (s[4:0] == 5'd0) ? 5'd1 : s[4:0];
    k = (kind == 3) ? int'(s[6:5]) % 3 : kind;
    case (k)
      0: begin
        imm = r[31:20];
        // shift immediates carry funct7 above the shift amount
        if (r[14:12] == 3'b001) imm = {7'b0, r[24:20]};
        if (r[14:12] == 3'b101) imm = {1'b0, s[7], 5'b0, r[24:20]};
        return {imm, r[19:15], r[14:12], rd, 7'b0010011};
      end
      1: begin
        f7 = (s[7] && (r[14:12] == 3'b000 || r[14:12] == 3'b101)) ? 7'b0100000 : 7'b0;
        return {f7, r[24:20], r[19:15], r[14:12], rd, 7'b0110011};
      end
      default: begin
        case (s[9:8])
          2'd0: return {r[31:12], s[14:10], 7'b0110111};
          2'd1: return {r[31:20], r[19:15], 3'b000, 5'd0, 7'b0010011};
          2'd2: return {7'b0, r[24:20], 5'd0, 3'b000, rd, 7'b0110011};
          default: return {r[31:20], 5'd0, 3'b110, rd, 7'b0010011};
        endcase
      end
    endcase
  endfunction

  // destination value under RV32I rules
  function automatic word_t ref_value(input word_t insn, input word_t a, input word_t rs2_val);
    word_t b;
    word_t sra;
    logic  is_reg;
    is_reg = (insn[6:0] == 7'b0110011);
    b = is_reg ? rs2_val : {{20{insn[31]}}, insn[31:20]};
    sra = $signed(a) >>> b[4:0];
    if (insn[6:0] == 7'b0110111) begin
      return {insn[31:12], 12'h000};
    end
    case (insn[14:12])
      3'b000: return (is_reg && insn[30]) ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return insn[30] ? sra : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // prog has 512 words, so pc bits 10:2 select the word
  always_comb begin
    exp_insn = prog[exp_pc[10:2]];
    exp_we = (exp_insn[6:0] == 7'b0010011) || (exp_insn[6:0] == 7'b0110011) ||
             (exp_insn[6:0] == 7'b0110111);
    exp_value = ref_value(exp_insn, model_regs[exp_insn[19:15]], model_regs[exp_insn[24:20]]);
  end

  // architectural state moves on with every retire
  always @(posedge clk) begin
    if (rst) begin
      exp_pc       <= start_pc;
      retire_count <= 0;
      for (int i = 0; i < 32; i++) begin
        model_regs[i] <= '0;
      end
    end else if (retire_valid) begin
      exp_pc       <= exp_pc + 32'd4;
      retire_count <= retire_count + 1;
      if (exp_we && (exp_insn[11:7] != 5'd0)) begin
        model_regs[exp_insn[11:7]] <= exp_value;
      end
    end
  end

  task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
    $display("MISMATCH %s: %s expected %08h actual %08h at %0t",
             test_name, what, expected, actual, $time);
    errors++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s: %s at %0t", test_name, what, $time);
    errors++;
  endtask

  // sampled on the falling edge where retire outputs are stable
  pc_in_order: assert property (@(negedge clk) disable iff (rst)
      retire_valid |-> retire.pc == exp_pc)
    else report_mismatch("retire pc", exp_pc, retire.pc);
  insn_matches: assert property (@(negedge clk) disable iff (rst)
      retire_valid |-> retire.insn == exp_insn)
    else report_mismatch("retire insn", exp_insn, retire.insn);
  rd_matches: assert property (@(negedge clk) disable iff (rst)
      retire_valid |-> retire.rd == exp_insn[11:7])
    else report_mismatch("rd", word_t'(exp_insn[11:7]), word_t'(retire.rd));
  we_matches: assert property (@(negedge clk) disable iff (rst)
      retire_valid |-> retire.rd_we == exp_we)
    else report_mismatch("rd_we", word_t'(exp_we), word_t'(retire.rd_we));
  value_matches: assert property (@(negedge clk) disable iff (rst)
      retire_valid && exp_we && (exp_insn[11:7] != 5'd0) |-> retire.rd_value == exp_value)
    else report_mismatch("rd value", exp_value, retire.rd_value);
  halt_with_ecall: assert property (@(negedge clk) disable iff (rst)
      retire_valid && (exp_insn == ecall_word) |-> halt)
    else report_error("halt_o is low while the ECALL retires");
  halt_cause: assert property (@(negedge clk) disable iff (rst)
      $rose(halt) |-> retire_valid && (retire.insn == ecall_word))
    else report_error("halt_o rose without an ECALL retiring");
  halt_sticky: assert property (@(negedge clk) disable iff (rst)
      $past(halt) |-> halt)
    else report_error("halt_o dropped before reset");
  quiet_after_halt: assert property (@(negedge clk) disable iff (rst)
      $past(halt) |-> !retire_valid)
    else report_error("an instruction retired after the halt");
  no_fetch_after_halt: assert property (@(negedge clk) disable iff (rst)
      halt |-> !imem_req_valid)
    else report_error("a fetch request was raised while halted");

  // valid ops everywhere else, so a fetch past ECALL would show up as a retire
  task automatic build_program(input int kind, input int body_len);
    int    base;
    word_t w;
    base = int'(start_pc[10:2]);
    for (int i = 0; i < mem_words; i++) begin
      prog[i] = gen_op(3);
    end
    for (int r = 1; r < 32; r++) begin
      w = rand_word();
      prog[base + 2 * r - 2] = {w[31:12], 5'(r), 7'b0110111};
      prog[base + 2 * r - 1] = {w[11:0], 5'(r), 3'b000, 5'(r), 7'b0010011};
    end
    for (int i = 0; i < body_len; i++) begin
      prog[base + init_len + i] = gen_op(kind);
    end
    prog[base + init_len + body_len] = ecall_word;
    prog_len = init_len + body_len + 1;
    for (int i = 0; i < mem_words; i++) begin
      imem_i.mem[i] = prog[i];
    end
  endtask

  task automatic run_test(input string name, input int kind, input int body_len,
                          input int stall);
    int cycles;
    int errors_before;
    @(negedge clk);
    rst <= 1'b1;
    stall_pct <= stall;
    test_name = name;
    errors_before = errors;
    build_program(kind, body_len);
    repeat (rst_cycles) @(negedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!halt && (cycles < prog_len * 20)) begin
      @(negedge clk);
      cycles++;
    end
    assert (halt) else report_error("halt_o never rose");
    // let the outstanding responses drain, nothing may retire meanwhile
    repeat (drain_cycles) @(negedge clk);
    assert (retire_count == prog_len)
      else report_mismatch("retire count", word_t'(prog_len), word_t'(retire_count));
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("test %-8s done: %0d retires in %0d cycles, %0d errors",
             name, retire_count, cycles, errors - errors_before);
  endtask

  initial begin
    run_test("reg_imm", 0, len_imm, 25);
    run_test("reg_reg", 1, len_reg, 25);
    run_test("lui_x0", 2, len_x0, 25);
    run_test("stall", 3, len_stall, 85);
    run_test("halt", 3, len_halt, 40);
    $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("ERROR %s: watchdog expired after %0d cycles", test_name, watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: dv/imem_model.sv
`timescale 1ns/1ps

module imem_model
  import rv_isa_pkg::*;
  import core_pkg::*;
#(
  parameter int mem_words = 512,
  parameter int seed_init = 1
) (
  input  logic      clk,
  input  logic      rst,
  input  int        stall_pct_i,
  input  logic      req_valid_i,
  input  imem_req_t req_i,
  output logic      req_ready_o,
  output logic      rsp_valid_o,
  output word_t     rsp_o
);

  localparam int idx_w = $clog2(mem_words);

  word_t  mem [mem_words];
  integer seed = seed_init;
  logic   accepted_q;
  word_t  accepted_pc_q;

  initial begin
    req_ready_o <= 1'b0;
    rsp_valid_o <= 1'b0;
    rsp_o       <= '0;
  end

  // a request counts as accepted at the rising edge where valid and ready meet
  always_ff @(posedge clk) begin
    accepted_q    <= !rst && req_valid_i && req_ready_o;
    accepted_pc_q <= req_i.pc;
  end

  // ready drops at random, the answer follows one cycle after acceptance
  always @(negedge clk) begin
    if (rst) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      req_ready_o <= ($unsigned($random(seed)) % 100) >= stall_pct_i;
      rsp_valid_o <= accepted_q;
      rsp_o       <= mem[accepted_pc_q[idx_w+1:2]];
    end
  end

endmodule

// File: logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
  import rv_isa_pkg::*;
  import core_pkg::*;
#(
  parameter int    queue_depth = 4,
  parameter word_t reset_pc    = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      imem_req_ready_i,
  output logic      imem_req_valid_o,
  output imem_req_t imem_req_o,
  input  logic      imem_rsp_valid_i,
  input  word_t     imem_rsp_i,
  output logic      retire_valid_o,
  output retire_t   retire_o,
  output logic      halt_o
);

  localparam int count_w = $clog2(queue_depth + 1);

  logic               push_valid;
  fetch_pkt_t         push_pkt;
  logic [count_w-1:0] queue_count;
  logic               pop_valid;
  logic               pop_ready;
  fetch_pkt_t         pop_pkt;

  fetch_unit #(
    .queue_depth (queue_depth),
    .reset_pc    (reset_pc)
  ) fetch_unit_i (
    .clk              (clk),
    .rst              (rst),
    .halt_i           (halt_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_o       (imem_req_o),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_i       (imem_rsp_i),
    .queue_count_i    (queue_count),
    .push_valid_o     (push_valid),
    .push_pkt_o       (push_pkt)
  );

  insn_queue #(
    .queue_depth (queue_depth)
  ) insn_queue_i (
    .clk          (clk),
    .rst          (rst),
    .push_valid_i (push_valid),
    .push_pkt_i   (push_pkt),
    .count_o      (queue_count),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_pkt_o    (pop_pkt)
  );

  exec_unit exec_unit_i (
    .clk            (clk),
    .rst            (rst),
    .pop_valid_i    (pop_valid),
    .pop_pkt_i      (pop_pkt),
    .pop_ready_o    (pop_ready),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .halt_o         (halt_o)
  );

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       pop_valid_i,
  input  fetch_pkt_t pop_pkt_i,
  output logic       pop_ready_o,
  output logic       retire_valid_o,
  output retire_t    retire_o,
  output logic       halt_o
);

  exec_state_t state_q;
  exec_state_t state_d;
  word_t       insn;
  opcode_t     opcode;
  reg_idx_t    rd_idx;
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  funct3_t     funct3;
  funct7_t     funct7;
  word_t       imm_i;
  word_t       imm_u;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       alu_b;
  shamt_t      shamt;
  logic        use_alt;
  word_t       sra_out;
  word_t       alu_out;
  word_t       result;
  logic        imm_form_ok;
  logic        reg_form_ok;
  logic        rd_we;
  logic        is_ecall;
  logic        fire;
  logic        retire_valid_q;
  retire_t     retire_q;

  // instruction fields
  assign insn = pop_pkt_i.insn;
  assign opcode = opcode_t'(insn[6:0]);
  assign rd_idx = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};

  regfile regfile_i (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1_idx),
    .rs2_i      (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (fire && rd_we),
    .rd_i       (rd_idx),
    .rd_data_i  (result)
  );

  // second operand is rs2 or the I-immediate, shifts take its low five bits
  assign alu_b = (opcode == op_reg_reg) ? rs2_data : imm_i;
  assign shamt = alu_b[4:0];
  assign use_alt = (funct7 == f7_alt);
  assign sra_out = $signed(rs1_data) >>> shamt;

  always_comb begin
    case (funct3)
      f3_add_sub: begin
        if (use_alt && (opcode == op_reg_reg)) begin
          alu_out = rs1_data - alu_b;
        end else begin
          alu_out = rs1_data + alu_b;
        end
      end
      f3_sll:     alu_out = rs1_data << shamt;
      f3_slt:     alu_out = word_t'($signed(rs1_data) < $signed(alu_b));
      f3_sltu:    alu_out = word_t'(rs1_data < alu_b);
      f3_xor:     alu_out = rs1_data ^ alu_b;
      f3_srl_sra: alu_out = use_alt ? sra_out : (rs1_data >> shamt);
      f3_or:      alu_out = rs1_data | alu_b;
      f3_and:     alu_out = rs1_data & alu_b;
      default:    alu_out = '0;
    endcase
  end

  // funct7 only matters for shifts in the immediate group
  assign imm_form_ok = (funct3 == f3_sll) ? (funct7 == f7_base) :
                       (funct3 == f3_srl_sra) ? (funct7 == f7_base || use_alt) : 1'b1;
  assign reg_form_ok = (funct7 == f7_base) ||
                       (use_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));

  // anything outside the subset retires without a register write
  always_comb begin
    rd_we = 1'b0;
    result = alu_out;
    is_ecall = 1'b0;
    case (opcode)
      op_reg_imm: rd_we = imm_form_ok;
      op_reg_reg: rd_we = reg_form_ok;
      op_lui: begin
        rd_we = 1'b1;
        result = imm_u;
      end
      op_system: is_ecall = (insn == insn_ecall);
      default: rd_we = 1'b0;
    endcase
  end

  assign pop_ready_o = pop_valid_i && (state_q == st_run);
  assign fire = pop_ready_o;

  always_comb begin
    state_d = state_q;
    if ((state_q == st_run) && fire && is_ecall) begin
      state_d = st_halted;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= st_run;
      retire_valid_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      retire_valid_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      retire_q <= '{pc: pop_pkt_i.pc, insn: insn, rd: rd_idx, rd_we: rd_we, rd_value: result};
    end
  end

  // halt rises on the same edge that retires the ECALL
  assign halt_o = (state_q == st_halted);
  assign retire_valid_o = retire_valid_q;
  assign retire_o = retire_q;

endmodule

// File: logic/insn_queue.sv
`timescale 1ns/1ps

module insn_queue
  import core_pkg::*;
#(
  parameter int queue_depth = 4
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               push_valid_i,
  input  fetch_pkt_t                         push_pkt_i,
  output logic [$clog2(queue_depth + 1)-1:0] count_o,
  output logic                               pop_valid_o,
  input  logic                               pop_ready_i,
  output fetch_pkt_t                         pop_pkt_o
);

  localparam int count_w = $clog2(queue_depth + 1);
  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

  fetch_pkt_t         mem_q [queue_depth];
  logic [ptr_w-1:0]   wr_q;
  logic [ptr_w-1:0]   rd_q;
  logic [count_w-1:0] count_q;
  logic               pop_fire;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(queue_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign count_o = count_q;
  assign pop_valid_o = (count_q != '0);
  assign pop_pkt_o = mem_q[rd_q];
  assign pop_fire = pop_valid_o && pop_ready_i;

  // fetch holds back requests by credit, a push never meets a full queue
  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      mem_q[wr_q] <= push_pkt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q    <= '0;
      rd_q    <= '0;
      count_q <= '0;
    end else begin
      if (push_valid_i) begin
        wr_q <= next_ptr(wr_q);
      end
      if (pop_fire) begin
        rd_q <= next_ptr(rd_q);
      end
      case ({push_valid_i, pop_fire})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import rv_isa_pkg::*;
  import core_pkg::*;
#(
  parameter int    queue_depth = 4,
  parameter word_t reset_pc    = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 halt_i,
  input  logic                                 imem_req_ready_i,
  output logic                                 imem_req_valid_o,
  output imem_req_t                            imem_req_o,
  input  logic                                 imem_rsp_valid_i,
  input  word_t                                imem_rsp_i,
  input  logic [$clog2(queue_depth + 1)-1:0]   queue_count_i,
  output logic                                 push_valid_o,
  output fetch_pkt_t                           push_pkt_o
);

  localparam int count_w = $clog2(queue_depth + 1);
  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

  word_t              pc_q;
  logic               run_q;
  word_t              pend_pc [queue_depth];
  logic [ptr_w-1:0]   pend_wr_q;
  logic [ptr_w-1:0]   pend_rd_q;
  logic [count_w-1:0] pend_cnt_q;
  logic [count_w:0]   credit_used;
  logic               credit_ok;
  logic               req_fire;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(queue_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // queued entries plus requests in flight must leave room for every response
  assign credit_used = {1'b0, queue_count_i} + {1'b0, pend_cnt_q};
  assign credit_ok = credit_used < (count_w + 1)'(queue_depth);

  // run_q keeps the request port quiet through the reset cycle
  assign imem_req_valid_o = run_q && !halt_i && credit_ok;
  assign imem_req_o = '{pc: pc_q};
  assign req_fire = imem_req_valid_o && imem_req_ready_i;

  // responses come back in request order, so the oldest pending pc matches
  assign push_valid_o = imem_rsp_valid_i;
  assign push_pkt_o = '{pc: pend_pc[pend_rd_q], insn: imem_rsp_i};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q       <= reset_pc;
      run_q      <= 1'b0;
      pend_wr_q  <= '0;
      pend_rd_q  <= '0;
      pend_cnt_q <= '0;
    end else begin
      run_q <= 1'b1;
      if (req_fire) begin
        pc_q      <= pc_q + word_t'(4);
        pend_wr_q <= next_ptr(pend_wr_q);
      end
      if (imem_rsp_valid_i) begin
        pend_rd_q <= next_ptr(pend_rd_q);
      end
      case ({req_fire, imem_rsp_valid_i})
        2'b10: pend_cnt_q <= pend_cnt_q + 1'b1;
        2'b01: pend_cnt_q <= pend_cnt_q - 1'b1;
        default: pend_cnt_q <= pend_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      pend_pc[pend_wr_q] <= pc_q;
    end
  end

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o,
  input  logic     we_i,
  input  reg_idx_t rd_i,
  input  word_t    rd_data_i
);

  word_t regs [num_regs];

  // reads are combinational, a write shows on the next cycle
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // x0 is never written so it keeps its reset value of zero
      if (we_i && (rd_i != '0)) begin
        regs[rd_i] <= rd_data_i;
      end
    end
  end

endmodule

// File: logic/core_pkg.sv
package core_pkg;
  import rv_isa_pkg::*;

  // one fetched instruction with its address
  typedef struct packed {
    word_t pc;
    word_t insn;
  } fetch_pkt_t;

  // instruction memory request payload
  typedef struct packed {
    word_t pc;
  } imem_req_t;

  // retire report, one per executed instruction
  typedef struct packed {
    word_t    pc;
    word_t    insn;
    reg_idx_t rd;
    logic     rd_we;
    word_t    rd_value;
  } retire_t;

  typedef enum logic {
    st_run,
    st_halted
  } exec_state_t;

endpackage

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

  // base integer width
  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [4:0] shamt_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_lui     = 7'b0110111,
    op_system  = 7'b1110011
  } opcode_t;

  // funct3 codes shared by the reg-imm and reg-reg groups
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct7 selects the alternate form (SUB, SRA, SRAI)
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  // full encoding of ECALL, all fields other than the opcode are zero
  localparam word_t insn_ecall = 32'h0000_0073;

endpackage
